// ==== logic/branch_defines.svh ====
`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

// data and pc width
`define XLEN 32

// reorder-buffer tag width
`define ROB_TAG_W 3

// reservation station size, index width must match
`define BRS_ENTRIES 8
`define BRS_IDX_W 3

`endif

// ==== logic/branch_pkg.sv ====
`include "branch_defines.svh"

package branch_pkg;

  // rv32i major opcodes handled here
  typedef enum logic [6:0] {
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011
  } opcode_e;

  // branch funct3 encodings
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } cmp_op_e;

  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

endpackage

// ==== logic/branch_ctrl.sv ====
`include "branch_defines.svh"

module branch_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_req,
  output logic                  issue_ack,
  input  logic [`BRS_ENTRIES-1:0] busy,
  input  logic [`BRS_ENTRIES-1:0] ready,
  output logic                  alloc,
  output logic [`BRS_IDX_W-1:0] alloc_idx,
  output logic                  pick,
  output logic [`BRS_IDX_W-1:0] pick_idx
);

  logic                  has_free;
  logic [`BRS_IDX_W-1:0] rr_ptr;
  logic [`BRS_IDX_W-1:0] cand;

  assign has_free = ~&busy;

  // accept only in the low phase of ack
  assign alloc = issue_req && !issue_ack && has_free;

  // lowest free entry
  always_comb begin
    alloc_idx = '0;
    for (int i = `BRS_ENTRIES - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        alloc_idx = `BRS_IDX_W'(i);
      end
    end
  end

  // first ready entry at or after the pointer
  always_comb begin
    pick = 1'b0;
    pick_idx = '0;
    cand = '0;
    for (int i = 0; i < `BRS_ENTRIES; i++) begin
      cand = rr_ptr + `BRS_IDX_W'(i);
      if (!pick && ready[cand]) begin
        pick = 1'b1;
        pick_idx = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_ack <= 1'b0;
      rr_ptr <= '0;
    end else begin
      if (alloc) begin
        issue_ack <= 1'b1;
      end else if (!issue_req) begin
        issue_ack <= 1'b0;
      end
      if (pick) begin
        rr_ptr <= pick_idx + 1'b1;
      end
    end
  end

  // the issuer holds req until it is acknowledged
  req_held_for_ack: assert property (@(posedge clk) disable iff (rst)
    issue_req && !issue_ack |=> issue_req);

  alloc_hits_free: assert property (@(posedge clk) disable iff (rst)
    alloc |-> !busy[alloc_idx]);

endmodule

// ==== logic/branch_station.sv ====
`include "branch_defines.svh"

module branch_station (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     alloc,
  input  logic [`BRS_IDX_W-1:0]    alloc_idx,
  input  logic                     pick,
  input  logic [`BRS_IDX_W-1:0]    pick_idx,
  input  branch_pkg::opcode_e      issue_opcode,
  input  branch_pkg::cmp_op_e      issue_funct3,
  input  logic [`XLEN-1:0]         issue_imm,
  input  logic [`XLEN-1:0]         issue_pc,
  input  branch_pkg::rob_tag_t     issue_tag,
  input  logic                     rs1_ready,
  input  logic [`XLEN-1:0]         rs1_value,
  input  branch_pkg::rob_tag_t     rs1_tag,
  input  logic                     rs2_ready,
  input  logic [`XLEN-1:0]         rs2_value,
  input  branch_pkg::rob_tag_t     rs2_tag,
  input  logic                     cdb_valid,
  input  branch_pkg::rob_tag_t     cdb_tag,
  input  logic [`XLEN-1:0]         cdb_value,
  output logic [`BRS_ENTRIES-1:0]  busy,
  output logic [`BRS_ENTRIES-1:0]  ready,
  output branch_pkg::opcode_e      sel_opcode,
  output branch_pkg::cmp_op_e      sel_funct3,
  output logic [`XLEN-1:0]         sel_pc,
  output logic [`XLEN-1:0]         sel_imm,
  output logic [`XLEN-1:0]         sel_rs1,
  output logic [`XLEN-1:0]         sel_rs2,
  output branch_pkg::rob_tag_t     sel_tag
);

  logic [`BRS_ENTRIES-1:0] busy_q;
  logic [`BRS_ENTRIES-1:0] rs1_rdy_q;
  logic [`BRS_ENTRIES-1:0] rs2_rdy_q;
  logic [`BRS_ENTRIES-1:0] rs1_wake;
  logic [`BRS_ENTRIES-1:0] rs2_wake;

  branch_pkg::opcode_e  opcode_q [`BRS_ENTRIES];
  branch_pkg::cmp_op_e  funct3_q [`BRS_ENTRIES];
  logic [`XLEN-1:0]     pc_q     [`BRS_ENTRIES];
  logic [`XLEN-1:0]     imm_q    [`BRS_ENTRIES];
  branch_pkg::rob_tag_t tag_q    [`BRS_ENTRIES];
  logic [`XLEN-1:0]     rs1_q    [`BRS_ENTRIES];
  logic [`XLEN-1:0]     rs2_q    [`BRS_ENTRIES];
  branch_pkg::rob_tag_t rs1_tag_q[`BRS_ENTRIES];
  branch_pkg::rob_tag_t rs2_tag_q[`BRS_ENTRIES];

  logic rs1_skip;
  logic rs2_skip;
  logic rs1_fwd;
  logic rs2_fwd;

  // jal needs no operands, jalr needs only rs1
  assign rs1_skip = (issue_opcode == branch_pkg::op_jal);
  assign rs2_skip = (issue_opcode != branch_pkg::op_branch);

  // operand broadcast on the very edge it is issued
  assign rs1_fwd = !rs1_ready && cdb_valid && (cdb_tag == rs1_tag);
  assign rs2_fwd = !rs2_ready && cdb_valid && (cdb_tag == rs2_tag);

  always_comb begin
    for (int i = 0; i < `BRS_ENTRIES; i++) begin
      rs1_wake[i] = cdb_valid && busy_q[i] && !rs1_rdy_q[i] && (rs1_tag_q[i] == cdb_tag);
      rs2_wake[i] = cdb_valid && busy_q[i] && !rs2_rdy_q[i] && (rs2_tag_q[i] == cdb_tag);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
      rs1_rdy_q <= '0;
      rs2_rdy_q <= '0;
    end else begin
      rs1_rdy_q <= rs1_rdy_q | rs1_wake;
      rs2_rdy_q <= rs2_rdy_q | rs2_wake;
      if (alloc) begin
        busy_q[alloc_idx] <= 1'b1;
        rs1_rdy_q[alloc_idx] <= rs1_skip || rs1_ready || rs1_fwd;
        rs2_rdy_q[alloc_idx] <= rs2_skip || rs2_ready || rs2_fwd;
      end
      // release the entry handed to resolve
      if (pick) begin
        busy_q[pick_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `BRS_ENTRIES; i++) begin
      if (rs1_wake[i]) begin
        rs1_q[i] <= cdb_value;
      end
      if (rs2_wake[i]) begin
        rs2_q[i] <= cdb_value;
      end
    end
    if (alloc) begin
      opcode_q[alloc_idx] <= issue_opcode;
      funct3_q[alloc_idx] <= issue_funct3;
      pc_q[alloc_idx] <= issue_pc;
      imm_q[alloc_idx] <= issue_imm;
      tag_q[alloc_idx] <= issue_tag;
      rs1_tag_q[alloc_idx] <= rs1_tag;
      rs2_tag_q[alloc_idx] <= rs2_tag;
      rs1_q[alloc_idx] <= rs1_ready ? rs1_value : cdb_value;
      rs2_q[alloc_idx] <= rs2_ready ? rs2_value : cdb_value;
    end
  end

  assign busy = busy_q;
  assign ready = busy_q & rs1_rdy_q & rs2_rdy_q;

  assign sel_opcode = opcode_q[pick_idx];
  assign sel_funct3 = funct3_q[pick_idx];
  assign sel_pc = pc_q[pick_idx];
  assign sel_imm = imm_q[pick_idx];
  assign sel_rs1 = rs1_q[pick_idx];
  assign sel_rs2 = rs2_q[pick_idx];
  assign sel_tag = tag_q[pick_idx];

  // picked entry must be busy with both operands in hand
  pick_is_ready: assert property (@(posedge clk) disable iff (rst)
    pick |-> ready[pick_idx]);

endmodule

// ==== logic/branch_compare.sv ====
`include "branch_defines.svh"

module branch_compare (
  input  branch_pkg::cmp_op_e op,
  input  logic [`XLEN-1:0]    a,
  input  logic [`XLEN-1:0]    b,
  output logic                br_en
);

  always_comb begin
    case (op)
      branch_pkg::beq:  br_en = (a == b);
      branch_pkg::bne:  br_en = (a != b);
      branch_pkg::blt:  br_en = ($signed(a) < $signed(b));
      branch_pkg::bge:  br_en = ($signed(a) >= $signed(b));
      branch_pkg::bltu: br_en = (a < b);
      branch_pkg::bgeu: br_en = (a >= b);
      // reserved funct3 values never branch
      default:          br_en = 1'b0;
    endcase
  end

endmodule

// ==== logic/branch_resolve.sv ====
`include "branch_defines.svh"

module branch_resolve (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pick,
  input  branch_pkg::opcode_e  sel_opcode,
  input  logic [`XLEN-1:0]     sel_pc,
  input  logic [`XLEN-1:0]     sel_imm,
  input  logic [`XLEN-1:0]     sel_rs1,
  input  branch_pkg::rob_tag_t sel_tag,
  input  logic                 br_en,
  output logic                 redirect_valid,
  output logic                 redirect_taken,
  output logic [`XLEN-1:0]     redirect_pc,
  output logic                 result_valid,
  output branch_pkg::rob_tag_t result_tag,
  output logic [`XLEN-1:0]     result_value
);

  logic             taken;
  logic             link_wr;
  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] link;
  logic [`XLEN-1:0] pc_rel;
  logic [`XLEN-1:0] reg_rel;

  assign link = sel_pc + `XLEN'd4;
  assign pc_rel = sel_pc + sel_imm;
  assign reg_rel = sel_rs1 + sel_imm;

  always_comb begin
    case (sel_opcode)
      branch_pkg::op_jal: begin
        taken = 1'b1;
        link_wr = 1'b1;
        target = pc_rel;
      end
      branch_pkg::op_jalr: begin
        taken = 1'b1;
        link_wr = 1'b1;
        target = {reg_rel[`XLEN-1:1], 1'b0};
      end
      default: begin
        // not taken falls through to the next instruction
        taken = br_en;
        link_wr = 1'b0;
        target = br_en ? pc_rel : link;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      redirect_valid <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      redirect_valid <= pick;
      result_valid <= pick && link_wr;
    end
  end

  always_ff @(posedge clk) begin
    redirect_taken <= taken;
    redirect_pc <= target;
    result_tag <= sel_tag;
    result_value <= link;
  end

endmodule

// ==== logic/branch_unit_top.sv ====
`include "branch_defines.svh"

module branch_unit_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_req,
  output logic                 issue_ack,
  input  branch_pkg::opcode_e  issue_opcode,
  input  branch_pkg::cmp_op_e  issue_funct3,
  input  logic [`XLEN-1:0]     issue_imm,
  input  logic [`XLEN-1:0]     issue_pc,
  input  branch_pkg::rob_tag_t issue_tag,
  input  logic                 rs1_ready,
  input  logic [`XLEN-1:0]     rs1_value,
  input  branch_pkg::rob_tag_t rs1_tag,
  input  logic                 rs2_ready,
  input  logic [`XLEN-1:0]     rs2_value,
  input  branch_pkg::rob_tag_t rs2_tag,
  input  logic                 cdb_valid,
  input  branch_pkg::rob_tag_t cdb_tag,
  input  logic [`XLEN-1:0]     cdb_value,
  output logic                 redirect_valid,
  output logic                 redirect_taken,
  output logic [`XLEN-1:0]     redirect_pc,
  output logic                 result_valid,
  output branch_pkg::rob_tag_t result_tag,
  output logic [`XLEN-1:0]     result_value
);

  logic [`BRS_ENTRIES-1:0] busy;
  logic [`BRS_ENTRIES-1:0] ready;
  logic                    alloc;
  logic [`BRS_IDX_W-1:0]   alloc_idx;
  logic                    pick;
  logic [`BRS_IDX_W-1:0]   pick_idx;
  branch_pkg::opcode_e     sel_opcode;
  branch_pkg::cmp_op_e     sel_funct3;
  logic [`XLEN-1:0]        sel_pc;
  logic [`XLEN-1:0]        sel_imm;
  logic [`XLEN-1:0]        sel_rs1;
  logic [`XLEN-1:0]        sel_rs2;
  branch_pkg::rob_tag_t    sel_tag;
  logic                    br_en;

  branch_ctrl i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .issue_req (issue_req),
    .issue_ack (issue_ack),
    .busy      (busy),
    .ready     (ready),
    .alloc     (alloc),
    .alloc_idx (alloc_idx),
    .pick      (pick),
    .pick_idx  (pick_idx)
  );

  branch_station i_station (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc),
    .alloc_idx    (alloc_idx),
    .pick         (pick),
    .pick_idx     (pick_idx),
    .issue_opcode (issue_opcode),
    .issue_funct3 (issue_funct3),
    .issue_imm    (issue_imm),
    .issue_pc     (issue_pc),
    .issue_tag    (issue_tag),
    .rs1_ready    (rs1_ready),
    .rs1_value    (rs1_value),
    .rs1_tag      (rs1_tag),
    .rs2_ready    (rs2_ready),
    .rs2_value    (rs2_value),
    .rs2_tag      (rs2_tag),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_value    (cdb_value),
    .busy         (busy),
    .ready        (ready),
    .sel_opcode   (sel_opcode),
    .sel_funct3   (sel_funct3),
    .sel_pc       (sel_pc),
    .sel_imm      (sel_imm),
    .sel_rs1      (sel_rs1),
    .sel_rs2      (sel_rs2),
    .sel_tag      (sel_tag)
  );

  branch_compare i_compare (
    .op    (sel_funct3),
    .a     (sel_rs1),
    .b     (sel_rs2),
    .br_en (br_en)
  );

  branch_resolve i_resolve (
    .clk            (clk),
    .rst            (rst),
    .pick           (pick),
    .sel_opcode     (sel_opcode),
    .sel_pc         (sel_pc),
    .sel_imm        (sel_imm),
    .sel_rs1        (sel_rs1),
    .sel_tag        (sel_tag),
    .br_en          (br_en),
    .redirect_valid (redirect_valid),
    .redirect_taken (redirect_taken),
    .redirect_pc    (redirect_pc),
    .result_valid   (result_valid),
    .result_tag     (result_tag),
    .result_value   (result_value)
  );

endmodule

// ==== testbench/branch_unit_tb.sv ====
`include "branch_defines.svh"

module branch_unit_tb;

  // jal 1, jalr 2, conditions 30, full station 9, unrelated tag 1, random mix 200
  localparam int num_instr = 243;
  localparam int cycle_limit = 40 * num_instr + 100;

  logic                 clk;
  logic                 rst;
  logic                 issue_req;
  logic                 issue_ack;
  branch_pkg::opcode_e  issue_opcode;
  branch_pkg::cmp_op_e  issue_funct3;
  logic [`XLEN-1:0]     issue_imm;
  logic [`XLEN-1:0]     issue_pc;
  branch_pkg::rob_tag_t issue_tag;
  logic                 rs1_ready;
  logic [`XLEN-1:0]     rs1_value;
  branch_pkg::rob_tag_t rs1_tag;
  logic                 rs2_ready;
  logic [`XLEN-1:0]     rs2_value;
  branch_pkg::rob_tag_t rs2_tag;
  logic                 cdb_valid;
  branch_pkg::rob_tag_t cdb_tag;
  logic [`XLEN-1:0]     cdb_value;
  logic                 redirect_valid;
  logic                 redirect_taken;
  logic [`XLEN-1:0]     redirect_pc;
  logic                 result_valid;
  branch_pkg::rob_tag_t result_tag;
  logic [`XLEN-1:0]     result_value;

  integer seed = 15929;
  int     cycles = 0;
  int     n_rows = 0;
  int     open_rows = 0;
  int     redirects = 0;

  // one expected row per issued instruction
  logic                 exp_taken  [256];
  logic [`XLEN-1:0]     exp_target [256];
  logic [`XLEN-1:0]     exp_link   [256];
  logic                 exp_wr     [256];
  branch_pkg::rob_tag_t exp_tag    [256];
  logic [`XLEN-1:0]     exp_pc     [256];
  logic                 row_open   [256];

  // value each result-bus tag carries until the next drain
  logic [`XLEN-1:0] src_val [8];

  branch_unit_top i_branch_unit_top (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_redirect(input logic got_taken, input logic [`XLEN-1:0] got_pc,
                                input logic want_taken, input logic [`XLEN-1:0] want_pc);
    if (got_pc !== want_pc) begin
      fail_now($sformatf("Mismatch at time %0t: redirect_pc got %h expected %h",
                         $time, got_pc, want_pc));
    end else if (got_taken !== want_taken) begin
      fail_now($sformatf("Mismatch at time %0t: redirect_taken got %b expected %b",
                         $time, got_taken, want_taken));
    end
  endtask

  task automatic check_result(input branch_pkg::rob_tag_t got_tag,
                              input logic [`XLEN-1:0] got_value,
                              input branch_pkg::rob_tag_t want_tag,
                              input logic [`XLEN-1:0] want_value);
    if (got_tag !== want_tag) begin
      fail_now($sformatf("Mismatch at time %0t: result_tag got %h expected %h",
                         $time, got_tag, want_tag));
    end else if (got_value !== want_value) begin
      fail_now($sformatf("Mismatch at time %0t: result_value got %h expected %h",
                         $time, got_value, want_value));
    end
  endtask

  function automatic void resolve_ref(input branch_pkg::opcode_e op,
                                      input branch_pkg::cmp_op_e f3,
                                      input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] imm,
                                      input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                                      output logic taken, output logic [`XLEN-1:0] target,
                                      output logic [`XLEN-1:0] link, output logic wr);
    logic cond;
    case (f3)
      branch_pkg::beq:  cond = (a == b);
      branch_pkg::bne:  cond = (a != b);
      branch_pkg::blt:  cond = ($signed(a) < $signed(b));
      branch_pkg::bge:  cond = !($signed(a) < $signed(b));
      branch_pkg::bltu: cond = (a < b);
      default:          cond = !(a < b);
    endcase
    link = pc + 32'd4;
    wr = (op != branch_pkg::op_branch);
    if (op == branch_pkg::op_jal) begin
      taken = 1'b1;
      target = pc + imm;
    end else if (op == branch_pkg::op_jalr) begin
      taken = 1'b1;
      target = (a + imm) & ~32'h1;
    end else begin
      taken = cond;
      target = cond ? pc + imm : pc + 32'd4;
    end
  endfunction

  function automatic branch_pkg::cmp_op_e pick_cond(input int k);
    case (k)
      0: return branch_pkg::beq;
      1: return branch_pkg::bne;
      2: return branch_pkg::blt;
      3: return branch_pkg::bge;
      4: return branch_pkg::bltu;
      default: return branch_pkg::bgeu;
    endcase
  endfunction

  // records the expected row, then runs the req/ack handshake
  task automatic issue(input branch_pkg::opcode_e op, input branch_pkg::cmp_op_e f3,
                       input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                       input logic a_rdy, input branch_pkg::rob_tag_t a_tag,
                       input logic b_rdy, input branch_pkg::rob_tag_t b_tag);
    int               row;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] va;
    logic [`XLEN-1:0] vb;
    logic             t_exp;
    logic [`XLEN-1:0] tgt;
    logic [`XLEN-1:0] lnk;
    logic             wr;
    row = n_rows;
    // pcs 4 KiB apart keep every redirect target unique
    pc = 32'(row + 1) << 12;
    imm = 32'((({$random(seed)} % 500) + 2) * 4);
    va = a_rdy ? a : src_val[a_tag];
    vb = b_rdy ? b : src_val[b_tag];
    resolve_ref(op, f3, pc, imm, va, vb, t_exp, tgt, lnk, wr);
    exp_taken[row] = t_exp;
    exp_target[row] = tgt;
    exp_link[row] = lnk;
    exp_wr[row] = wr;
    exp_tag[row] = branch_pkg::rob_tag_t'(row);
    exp_pc[row] = pc;
    row_open[row] = 1'b1;
    n_rows++;
    open_rows++;
    @(posedge clk);
    issue_req <= 1'b1;
    issue_opcode <= op;
    issue_funct3 <= f3;
    issue_pc <= pc;
    issue_imm <= imm;
    issue_tag <= branch_pkg::rob_tag_t'(row);
    rs1_ready <= a_rdy;
    rs1_value <= a_rdy ? a : $random(seed);
    rs1_tag <= a_tag;
    rs2_ready <= b_rdy;
    rs2_value <= b_rdy ? b : $random(seed);
    rs2_tag <= b_tag;
    do @(negedge clk); while (!issue_ack);
    @(posedge clk);
    issue_req <= 1'b0;
    do @(negedge clk); while (issue_ack);
  endtask

  task automatic broadcast(input branch_pkg::rob_tag_t t);
    @(posedge clk);
    cdb_valid <= 1'b1;
    cdb_tag <= t;
    cdb_value <= src_val[t];
    @(posedge clk);
    cdb_valid <= 1'b0;
  endtask

  task automatic broadcast_shuffled();
    branch_pkg::rob_tag_t order [8];
    branch_pkg::rob_tag_t tmp;
    int                   j;
    for (int i = 0; i < 8; i++) begin
      order[i] = branch_pkg::rob_tag_t'(i);
    end
    for (int i = 7; i > 0; i--) begin
      j = {$random(seed)} % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 8; i++) begin
      broadcast(order[i]);
    end
  endtask

  task automatic randomize_sources();
    for (int t = 0; t < 8; t++) begin
      src_val[t] = $random(seed);
    end
  endtask

  task automatic random_instr();
    int                  kind;
    branch_pkg::opcode_e op;
    kind = {$random(seed)} % 4;
    op = (kind == 0) ? branch_pkg::op_jal :
         (kind == 1) ? branch_pkg::op_jalr : branch_pkg::op_branch;
    issue(op, pick_cond({$random(seed)} % 6), $random(seed), $random(seed),
          1'($random(seed)), branch_pkg::rob_tag_t'($random(seed)),
          1'($random(seed)), branch_pkg::rob_tag_t'($random(seed)));
  endtask

  task automatic wait_drained();
    do @(negedge clk); while (open_rows != 0);
  endtask

  // redirect row found by target, result checked against the same row
  always @(negedge clk) begin
    int hit;
    int page_hit;
    if (!rst && (redirect_valid || result_valid)) begin
      hit = -1;
      page_hit = -1;
      for (int r = 0; r < n_rows; r++) begin
        if (row_open[r] && exp_target[r] == redirect_pc) begin
          hit = r;
        end
        if (row_open[r] && exp_pc[r][`XLEN-1:12] == redirect_pc[`XLEN-1:12]) begin
          page_hit = r;
        end
      end
      // a wrong pc-relative target still lands in the page of its own pc
      if (hit < 0) begin
        hit = page_hit;
      end
      if (!redirect_valid) begin
        fail_now("link value written without a redirect");
      end else if (hit < 0) begin
        fail_now($sformatf("redirect to %h matches no pending instruction", redirect_pc));
      end else begin
        check_redirect(redirect_taken, redirect_pc, exp_taken[hit], exp_target[hit]);
        if (exp_wr[hit] && !result_valid) begin
          fail_now("jump resolved without writing its link value");
        end else if (!exp_wr[hit] && result_valid) begin
          fail_now("conditional branch wrote a link value");
        end else if (exp_wr[hit]) begin
          check_result(result_tag, result_value, exp_tag[hit], exp_link[hit]);
        end
        row_open[hit] = 1'b0;
        open_rows--;
        redirects++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      fail_now($sformatf("timeout after %0d cycles, %0d instructions unresolved",
                         cycles, open_rows));
    end
  end

  initial begin
    logic [`XLEN-1:0] v;
    int               c0;
    rst <= 1'b1;
    issue_req <= 1'b0;
    issue_opcode <= branch_pkg::op_branch;
    issue_funct3 <= branch_pkg::beq;
    issue_imm <= '0;
    issue_pc <= '0;
    issue_tag <= '0;
    rs1_ready <= 1'b0;
    rs1_value <= '0;
    rs1_tag <= '0;
    rs2_ready <= 1'b0;
    rs2_value <= '0;
    rs2_tag <= '0;
    cdb_valid <= 1'b0;
    cdb_tag <= '0;
    cdb_value <= '0;
    randomize_sources();
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    issue(branch_pkg::op_jal, branch_pkg::beq, 0, 0, 1'b1, 3'd0, 1'b1, 3'd0);
    wait_drained();

    // jalr with rs1 at issue, then rs1 from the result bus
    issue(branch_pkg::op_jalr, branch_pkg::beq, 32'h9000_0001, 0, 1'b1, 3'd0, 1'b1, 3'd0);
    wait_drained();
    src_val[4] = 32'h9100_0003;
    issue(branch_pkg::op_jalr, branch_pkg::beq, 0, 0, 1'b0, 3'd4, 1'b1, 3'd0);
    broadcast(3'd4);
    wait_drained();

    for (int k = 0; k < 6; k++) begin
      issue(branch_pkg::op_branch, pick_cond(k), 32'h8000_0000, 32'h7fff_ffff,
            1'b1, 3'd0, 1'b1, 3'd0);
      issue(branch_pkg::op_branch, pick_cond(k), 32'hffff_ffff, 32'h0000_0001,
            1'b1, 3'd0, 1'b1, 3'd0);
      v = $random(seed);
      issue(branch_pkg::op_branch, pick_cond(k), v, v, 1'b1, 3'd0, 1'b1, 3'd0);
      repeat (2) begin
        issue(branch_pkg::op_branch, pick_cond(k), $random(seed), $random(seed),
              1'b1, 3'd0, 1'b1, 3'd0);
      end
    end
    wait_drained();

    // fill the station with waiting branches, then one more must stall
    randomize_sources();
    for (int k = 0; k < 8; k++) begin
      issue(branch_pkg::op_branch, pick_cond(k % 6), 0, 0,
            1'b0, branch_pkg::rob_tag_t'(k), 1'b0, branch_pkg::rob_tag_t'(k + 3));
    end
    fork
      issue(branch_pkg::op_branch, branch_pkg::bne, 1, 2, 1'b1, 3'd0, 1'b1, 3'd0);
      begin
        repeat (10) begin
          @(negedge clk);
          if (issue_ack || redirect_valid) begin
            fail_now("full station accepted or resolved work before any operand arrived");
          end
        end
        broadcast_shuffled();
      end
    join
    wait_drained();

    issue(branch_pkg::op_branch, branch_pkg::bltu, 0, 32'h10, 1'b0, 3'd2, 1'b1, 3'd0);
    c0 = redirects;
    broadcast(3'd5);
    repeat (10) @(negedge clk);
    if (redirects != c0) begin
      fail_now("entry resolved on an unrelated result-bus tag");
    end
    broadcast(3'd2);
    wait_drained();

    for (int b = 0; b < 25; b++) begin
      randomize_sources();
      fork
        repeat (8) random_instr();
        repeat (6) broadcast(branch_pkg::rob_tag_t'($random(seed)));
      join
      for (int t = 0; t < 8; t++) begin
        broadcast(branch_pkg::rob_tag_t'(t));
      end
      wait_drained();
    end

    if (open_rows == 0 && n_rows == num_instr) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_now($sformatf("%0d of %0d instructions unresolved, %0d expected in total",
                         open_rows, n_rows, num_instr));
    end
  end

endmodule

// ==== list.f ====
+incdir+logic
logic/branch_pkg.sv
logic/branch_ctrl.sv
logic/branch_station.sv
logic/branch_compare.sv
logic/branch_resolve.sv
logic/branch_unit_top.sv
testbench/branch_unit_tb.sv
